// File: source/loader_pkg.sv
package loader_pkg;

	// ==============================
	// Loader stream
	// ==============================
	localparam int addr_w = 27; // Byte address bits from the loader

	typedef logic [15:0]       half_t;      // Low byte is the earlier file byte
	typedef logic [7:0]        index_t;     // Download slot selected in the menu
	typedef logic [addr_w-1:0] byte_addr_t;
	typedef logic [addr_w-3:0] pak_addr_t;  // Byte address >> 2

	localparam index_t idx_bios  = 8'd0;   // Boot ROM image
	localparam index_t idx_cheat = 8'd255; // Cheat list, everything else is a cart

	// ==============================
	// Assembled payloads
	// ==============================
	typedef logic [31:0]  bios_word_t;
	typedef logic [11:0]  bios_addr_t; // 16 KB BIOS in words

	// Code fields from the top: flags, address, compare, replace
	// Each field is 32 bits
	typedef logic [127:0] cheat_code_t;

	typedef enum logic [1:0] {
		kind_none,  // Idle, no download
		kind_bios,
		kind_cart,
		kind_cheat
	} kind_t;

	// ==============================
	// Cart header and quirks
	// ==============================
	typedef logic [95:0] title_t;                  // 12 ASCII chars, first char on top
	localparam byte_addr_t title_base = 27'h0A0;   // Game title field of the header
	localparam logic [71:0] flash_tag = "FLASH1M_V"; // Library tag of 128 KB flash games

	typedef struct packed {
		logic sram;  // Save memory path disabled
		logic remap; // ROM mirrored like the NES classics
	} quirk_t;

	typedef struct packed {
		title_t title;
		quirk_t flags;
	} title_entry_t;

	localparam int n_titles = 8;

	// Short titles padded with zero bytes, as stored in the header
	localparam title_entry_t title_table [n_titles] = '{
		'{"ROCKY BOXING",              2'b10}, // Save RAM only
		'{"DBZ LGCYGOKU",              2'b10},
		'{{"TOPGUN CZ", 24'h000000},   2'b10},
		'{{"IRIDIONII", 24'h000000},   2'b10},
		'{{"BOMBER MAN", 16'h0000},    2'b11}, // NES classics, both quirks
		'{{"CASTLEVANIA", 8'h00},      2'b11},
		'{{"SUPER MARIO", 8'h00},      2'b11},
		'{{"ZELDA 1", 40'h0000000000}, 2'b11}
	};

endpackage

// File: source/download_decoder.sv
module download_decoder (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active,
	input  loader_pkg::index_t     dl_index,
	input  loader_pkg::byte_addr_t dl_addr,
	input  loader_pkg::half_t      dl_data,
	input  logic                   dl_wr,
	output loader_pkg::kind_t      wr_kind,
	output loader_pkg::byte_addr_t wr_addr,
	output loader_pkg::half_t      wr_data,
	output logic                   wr_strobe,
	output logic                   cart_start,
	output logic                   cart_end,
	output logic                   cheat_clear
);

	loader_pkg::kind_t dl_kind; // Kind of the current index before the register
	logic active_q;             // dl_active one cycle back
	logic dl_rise;
	logic dl_fall;
	logic cart_open;            // Between cart_start and cart_end

	// Any slot other than 0 and 255 carries a ROM
	always_comb begin
		if (dl_index == loader_pkg::idx_bios)
			dl_kind = loader_pkg::kind_bios;
		else if (dl_index == loader_pkg::idx_cheat)
			dl_kind = loader_pkg::kind_cheat;
		else
			dl_kind = loader_pkg::kind_cart;
	end

	assign dl_rise = dl_active & ~active_q;
	assign dl_fall = ~dl_active & active_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_q    <= 1'b0;
			wr_kind     <= loader_pkg::kind_none;
			wr_strobe   <= 1'b0;
			cart_start  <= 1'b0;
			cart_end    <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			active_q    <= dl_active;
			wr_kind     <= dl_active ? dl_kind : loader_pkg::kind_none;
			wr_strobe   <= dl_active & dl_wr;                      // Strobes outside a download dropped
			cart_start  <= dl_rise && dl_kind == loader_pkg::kind_cart;
			cart_end    <= dl_fall && wr_kind == loader_pkg::kind_cart; // Kind of the last active cycle
			cheat_clear <= dl_rise && dl_kind == loader_pkg::kind_cheat;
		end
	end

	// Write payload follows the stream only on a strobe
	always_ff @(posedge clk_sys) begin
		if (dl_wr) begin
			wr_addr <= dl_addr;
			wr_data <= dl_data;
		end
	end

	// ROM download bracket
	always_ff @(posedge clk_sys) begin
		if (reset)
			cart_open <= 1'b0;
		else if (cart_start)
			cart_open <= 1'b1;
		else if (cart_end)
			cart_open <= 1'b0;
	end

	// Each ROM download closes before the next one opens
	a_start_end_paired: assert property (@(posedge clk_sys) disable iff (reset)
		(cart_start || cart_end) |-> cart_open == cart_end);

endmodule

// File: source/flash_tag_scanner.sv
module flash_tag_scanner (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                cart_start,
	input  loader_pkg::kind_t   wr_kind,
	input  loader_pkg::half_t   wr_data,
	input  logic                wr_strobe,
	output logic                tag_found
);

	logic [63:0] history;   // Last eight ROM bytes, newest in the low byte
	logic [63:0] hist_base; // History as seen by this write
	logic        cart_wr;
	logic        hit_lo;    // Tag ends on the low (earlier) byte
	logic        hit_hi;    // Tag ends on the high byte

	assign cart_wr   = wr_strobe && wr_kind == loader_pkg::kind_cart;
	assign hist_base = cart_start ? 64'd0 : history; // New ROM starts from an empty window

	// Nine bytes compared at both byte alignments
	assign hit_lo = {hist_base, wr_data[7:0]} == loader_pkg::flash_tag;
	assign hit_hi = {hist_base[55:0], wr_data[7:0], wr_data[15:8]} == loader_pkg::flash_tag;

	always_ff @(posedge clk_sys) begin
		if (cart_wr)
			history <= {hist_base[47:0], wr_data[7:0], wr_data[15:8]};
		else if (cart_start)
			history <= 64'd0;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			tag_found <= 1'b0;
		end else begin
			if (cart_start)
				tag_found <= 1'b0;                // Cleared per cartridge
			if (cart_wr && (hit_lo || hit_hi))
				tag_found <= 1'b1;                // Sticky for the rest of the ROM
		end
	end

endmodule

// File: source/title_quirk_matcher.sv
module title_quirk_matcher (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cart_start,
	input  loader_pkg::kind_t      wr_kind,
	input  loader_pkg::byte_addr_t wr_addr,
	input  loader_pkg::half_t      wr_data,
	input  logic                   wr_strobe,
	output loader_pkg::quirk_t     quirk
);

	// ==============================
	// Title capture
	// ==============================
	loader_pkg::title_t     title_q;  // Header title, first char on top
	loader_pkg::byte_addr_t hdr_off;  // Offset from the title start
	logic [6:0]             slot_lsb; // Bit position of the halfword in title_q
	logic                   cart_wr;
	logic                   in_title;
	logic                   at_lookup;

	assign cart_wr   = wr_strobe && wr_kind == loader_pkg::kind_cart;
	assign hdr_off   = wr_addr - loader_pkg::title_base; // Wraps high below the title
	assign in_title  = hdr_off < 27'd12;
	assign at_lookup = hdr_off == 27'd12;                 // Halfword right after the title
	assign slot_lsb  = {4'd10 - hdr_off[3:0], 3'd0};

	// Earlier byte goes higher, so the text reads left to right
	always_ff @(posedge clk_sys) begin
		if (cart_wr && in_title)
			title_q[slot_lsb +: 16] <= {wr_data[7:0], wr_data[15:8]};
	end

	// ==============================
	// Table lookup
	// ==============================
	loader_pkg::quirk_t table_hit;

	always_comb begin
		table_hit = '0;
		for (int i = 0; i < loader_pkg::n_titles; i++) begin
			if (title_q == loader_pkg::title_table[i].title)
				table_hit = table_hit | loader_pkg::title_table[i].flags;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			quirk <= '0;
		end else begin
			if (cart_start)
				quirk <= '0;         // Unlisted titles keep both flags low
			if (cart_wr && at_lookup)
				quirk <= table_hit;  // Title complete by now
		end
	end

endmodule

// File: source/cart_profile.sv
module cart_profile (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cart_start,
	input  logic                   cart_end,
	input  loader_pkg::kind_t      wr_kind,
	input  loader_pkg::byte_addr_t wr_addr,
	input  logic                   wr_strobe,
	input  logic                   tag_found,
	input  loader_pkg::quirk_t     quirk,
	output logic                   flash_1m,
	output logic                   sram_quirk,
	output logic                   remap_quirk,
	output loader_pkg::pak_addr_t  max_pak_addr,
	output logic                   profile_valid
);

	loader_pkg::byte_addr_t last_addr; // Byte address of the latest ROM write
	logic                   cart_wr;

	assign cart_wr = wr_strobe && wr_kind == loader_pkg::kind_cart;

	always_ff @(posedge clk_sys) begin
		if (cart_wr)
			last_addr <= wr_addr;
	end

	// ==============================
	// Profile latch
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			flash_1m      <= 1'b0;
			sram_quirk    <= 1'b0;
			remap_quirk   <= 1'b0;
			profile_valid <= 1'b0;
		end else if (cart_end) begin
			flash_1m      <= tag_found;
			sram_quirk    <= quirk.sram;
			remap_quirk   <= quirk.remap;
			profile_valid <= 1'b1;
		end else if (cart_start) begin
			profile_valid <= 1'b0; // Old profile stays visible but stale
		end
	end

	// Word address of the last data, for reads past the ROM end
	always_ff @(posedge clk_sys) begin
		if (cart_end)
			max_pak_addr <= last_addr[loader_pkg::addr_w-1:2];
	end

	// First strobe may share the cycle with cart_start
	a_no_write_while_valid: assert property (@(posedge clk_sys) disable iff (reset)
		cart_wr && !cart_start |-> !profile_valid);

endmodule

// File: source/halfword_packer.sv
module halfword_packer #(
	parameter type payload_t = logic [31:0],
	parameter type slot_t    = logic [11:0]
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   active,
	input  loader_pkg::byte_addr_t addr,
	input  loader_pkg::half_t      data,
	input  logic                   strobe,
	output payload_t               payload,
	output slot_t                  index,
	output logic                   done
);

	localparam int p_bits  = $bits(payload_t);
	localparam int n_bytes = p_bits / 8;
	localparam int off_w   = $clog2(n_bytes); // Address bits inside one payload

	logic [off_w-2:0] half_sel; // Halfword number within the payload
	logic [off_w-2:0] n_taken;  // Halfwords taken so far in this payload
	logic             last_half;
	logic             take;
	int               bit_pos;

	assign half_sel  = addr[off_w-1:1];
	assign last_half = half_sel == {(off_w-1){1'b1}};
	assign take      = active & strobe;

	// 32-bit fields fill from the top with the lower half of each first
	always_comb begin
		bit_pos = p_bits - 32 * (int'(half_sel >> 1) + 1) + 16 * int'(half_sel[0]);
	end

	always_ff @(posedge clk_sys) begin
		if (take)
			payload[bit_pos +: 16] <= data;
		if (take && last_half)
			index <= addr[off_w +: $bits(slot_t)]; // Byte address / payload size
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			done <= 1'b0;
		else
			done <= take & last_half; // Payload complete on this edge
	end

	// Restarts with every download
	always_ff @(posedge clk_sys) begin
		if (reset || !active)
			n_taken <= '0;
		else if (strobe)
			n_taken <= n_taken + 1'b1; // Wraps to zero once the payload is full
	end

	// Halfwords arrive in address order so done marks a complete payload
	a_halves_in_order: assert property (@(posedge clk_sys) disable iff (reset)
		take |-> half_sel == n_taken);

endmodule

// File: source/gba_loader.sv
module gba_loader (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      dl_active,
	input  loader_pkg::index_t        dl_index,
	input  loader_pkg::byte_addr_t    dl_addr,
	input  loader_pkg::half_t         dl_data,
	input  logic                      dl_wr,
	output logic                      flash_1m,
	output logic                      sram_quirk,
	output logic                      remap_quirk,
	output loader_pkg::pak_addr_t     max_pak_addr,
	output logic                      profile_valid,
	output loader_pkg::bios_addr_t    bios_addr,
	output loader_pkg::bios_word_t    bios_data,
	output logic                      bios_wr,
	output loader_pkg::cheat_code_t   cheat_code,
	output logic                      cheat_valid,
	output logic                      cheat_clear
);

	// ==============================
	// Registered stream
	// ==============================
	loader_pkg::kind_t      wr_kind;
	loader_pkg::byte_addr_t wr_addr;
	loader_pkg::half_t      wr_data;
	logic                   wr_strobe;
	logic                   cart_start; // First cycle of a ROM download
	logic                   cart_end;   // First cycle after it
	logic                   tag_found;
	loader_pkg::quirk_t     quirk;

	download_decoder decoder_inst (
		.clk_sys, .reset,
		.dl_active, .dl_index, .dl_addr, .dl_data, .dl_wr,
		.wr_kind, .wr_addr, .wr_data, .wr_strobe,
		.cart_start, .cart_end, .cheat_clear
	);

	// ==============================
	// Cartridge profile
	// ==============================
	flash_tag_scanner scanner_inst (
		.clk_sys, .reset, .cart_start,
		.wr_kind, .wr_data, .wr_strobe,
		.tag_found
	);

	title_quirk_matcher matcher_inst (
		.clk_sys, .reset, .cart_start,
		.wr_kind, .wr_addr, .wr_data, .wr_strobe,
		.quirk
	);

	cart_profile profile_inst (
		.clk_sys, .reset, .cart_start, .cart_end,
		.wr_kind, .wr_addr, .wr_strobe,
		.tag_found, .quirk,
		.flash_1m, .sram_quirk, .remap_quirk, .max_pak_addr, .profile_valid
	);

	// ==============================
	// BIOS words and cheat codes
	// ==============================
	halfword_packer #(
		.payload_t (loader_pkg::bios_word_t),
		.slot_t    (loader_pkg::bios_addr_t)
	) bios_packer (
		.clk_sys, .reset,
		.active  (wr_kind == loader_pkg::kind_bios),
		.addr    (wr_addr),
		.data    (wr_data),
		.strobe  (wr_strobe),
		.payload (bios_data),
		.index   (bios_addr), // Word address into the BIOS ROM
		.done    (bios_wr)
	);

	halfword_packer #(
		.payload_t (loader_pkg::cheat_code_t),
		.slot_t    (logic [loader_pkg::addr_w-5:0])
	) cheat_packer (
		.clk_sys, .reset,
		.active  (wr_kind == loader_pkg::kind_cheat),
		.addr    (wr_addr),
		.data    (wr_data),
		.strobe  (wr_strobe),
		.payload (cheat_code),
		.index   (),          // Codes are consumed in order, slot not needed
		.done    (cheat_valid)
	);

endmodule

// File: bench/stream_table.svh
`ifndef STREAM_TABLE_SVH
`define STREAM_TABLE_SVH

// Columns: name, index, length in bytes, header title, tag offset (-1 for none),
// expected flash, sram, remap, expected max pak address, base payload words
typedef struct packed {
	logic [95:0]           name;    // Padded to 12 chars
	loader_pkg::index_t    index;
	int                    len;     // Even, in bytes
	loader_pkg::title_t    title;   // Placed at 0xA0 for carts
	int                    tag_off; // First byte of FLASH1M_V
	logic                  flash;
	logic                  sram;
	logic                  remap;
	loader_pkg::pak_addr_t max_pak; // (len - 2) / 4
	logic [0:3][31:0]      words;   // File word k is words[k % 4] ^ k
} row_t;

localparam int n_rows = 7;

localparam row_t stream_table [n_rows] = '{
	'{"rocky_sram  ", 8'd1, 'h100, "ROCKY BOXING", -1, 1'b0, 1'b1, 1'b0, 25'h03F, '0},
	'{"mario_remap ", 8'd2, 'h0C2, {"SUPER MARIO", 8'h00}, 'h040, 1'b1, 1'b1, 1'b1,
		25'h030, '0},                                                       // Even tag
	'{"odd_tag     ", 8'd3, 'h136, "NO SUCH GAME", 'h071, 1'b1, 1'b0, 1'b0, 25'h04D, '0},
	'{"plain_cart  ", 8'd7, 'h0B0, "NO SUCH GAME", -1, 1'b0, 1'b0, 1'b0, 25'h02B, '0},
	'{"zelda_remap ", 8'd9, 'h0B2, {"ZELDA 1", 40'h0}, 'h007, 1'b1, 1'b1, 1'b1, 25'h02C, '0},
	'{"bios_words  ", 8'd0, 'h040, '0, -1, 1'b0, 1'b0, 1'b0, '0,
		'{32'hEA00_0018, 32'hEA00_0004, 32'hE129_F000, 32'hE59F_D0D0}},  // 16 words
	'{"cheat_codes ", 8'd255, 'h030, '0, -1, 1'b0, 1'b0, 1'b0, '0,
		'{32'h0000_0003, 32'h0200_1234, 32'h0000_00FF, 32'h0000_0063}}   // 3 codes
};

`endif

// File: bench/gba_loader_tb.sv
module gba_loader_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic                    clk_sys;
	logic                    reset;
	logic                    dl_active;
	loader_pkg::index_t      dl_index;
	loader_pkg::byte_addr_t  dl_addr;
	loader_pkg::half_t       dl_data;
	logic                    dl_wr;
	logic                    flash_1m;
	logic                    sram_quirk;
	logic                    remap_quirk;
	loader_pkg::pak_addr_t   max_pak_addr;
	logic                    profile_valid;
	loader_pkg::bios_addr_t  bios_addr;
	loader_pkg::bios_word_t  bios_data;
	logic                    bios_wr;
	loader_pkg::cheat_code_t cheat_code;
	logic                    cheat_valid;
	logic                    cheat_clear;

	`include "stream_table.svh"

	loader_pkg::bios_word_t  word_q [$];  // Every BIOS word seen in order
	loader_pkg::bios_addr_t  waddr_q [$];
	loader_pkg::cheat_code_t code_q [$];
	int clears         = 0;               // cheat_clear pulses so far
	int codes_at_clear = 0;               // Codes seen when the last clear came
	int mismatches     = 0;
	int timeouts       = 0;

	gba_loader gba_loader_inst (
		.clk_sys, .reset, .dl_active, .dl_index, .dl_addr, .dl_data, .dl_wr,
		.flash_1m, .sram_quirk, .remap_quirk, .max_pak_addr, .profile_valid,
		.bios_addr, .bios_data, .bios_wr, .cheat_code, .cheat_valid, .cheat_clear
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys; // 4 ns period
	end

	// Results picked up at negedge half a cycle clear of the driving edge
	always @(negedge clk_sys) begin
		if (bios_wr) begin
			word_q.push_back(bios_data);
			waddr_q.push_back(bios_addr);
		end
		if (cheat_valid)
			code_q.push_back(cheat_code);
		if (cheat_clear) begin
			clears++;
			codes_at_clear = code_q.size();
		end
	end

	// ==============================
	// Compare tasks
	// ==============================
	task automatic check_profile(input logic [95:0] name, input logic [2:0] exp_flags,
			input loader_pkg::pak_addr_t exp_max);
		if ({flash_1m, sram_quirk, remap_quirk} !== exp_flags || max_pak_addr !== exp_max) begin
			mismatches++;
			$display("MISMATCH %s profile: expected flags %b max %h, actual flags %b max %h",
				name, exp_flags, exp_max, {flash_1m, sram_quirk, remap_quirk}, max_pak_addr);
		end
	endtask

	task automatic check_bios(input logic [95:0] name,
			input loader_pkg::bios_word_t exp_word, input loader_pkg::bios_addr_t exp_addr,
			input loader_pkg::bios_word_t act_word, input loader_pkg::bios_addr_t act_addr);
		if (act_word !== exp_word || act_addr !== exp_addr) begin
			mismatches++;
			$display("MISMATCH %s BIOS word: expected %h @ %h, actual %h @ %h",
				name, exp_word, exp_addr, act_word, act_addr);
		end
	endtask

	task automatic check_code(input logic [95:0] name, input int j,
			input loader_pkg::cheat_code_t exp_code, input loader_pkg::cheat_code_t act_code);
		if (act_code !== exp_code) begin
			mismatches++;
			$display("MISMATCH %s code %0d: expected %h, actual %h", name, j, exp_code, act_code);
		end
	endtask

	task automatic check_bit(input logic [95:0] name, input string what,
			input logic exp_bit, input logic act_bit);
		if (act_bit !== exp_bit) begin
			mismatches++;
			$display("MISMATCH %s %s: expected %b, actual %b", name, what, exp_bit, act_bit);
		end
	endtask

	// ==============================
	// Stream generation
	// ==============================
	function automatic loader_pkg::bios_word_t word_at(input row_t row, input int k);
		return row.words[k % 4] ^ 32'(k); // Varies each word of the file
	endfunction

	// Random ROM byte unless the title or the tag covers it
	function automatic logic [7:0] cart_byte(input row_t row, input int i);
		logic [7:0] b;
		int         t;
		b = 8'($urandom());
		t = i - int'(loader_pkg::title_base);
		if (t >= 0 && t < 12)
			b = row.title[95 - 8 * t -: 8];            // First char on top
		if (row.tag_off >= 0 && i >= row.tag_off && i < row.tag_off + 9)
			b = loader_pkg::flash_tag[71 - 8 * (i - row.tag_off) -: 8];
		return b;
	endfunction

	// One halfword write followed by 0 to 3 idle cycles
	task automatic write_half(input loader_pkg::byte_addr_t addr, input loader_pkg::half_t data);
		int gap;
		@(posedge clk_sys);
		dl_addr <= addr;
		dl_data <= data;
		dl_wr   <= 1'b1;
		gap = $urandom_range(3);
		repeat (gap) begin
			@(posedge clk_sys);
			dl_wr <= 1'b0;
		end
	endtask

	task automatic run_row(input row_t row);
		logic [7:0]              rom [$];
		loader_pkg::bios_word_t  w;
		loader_pkg::cheat_code_t code;
		int                      base_w;
		int                      base_c;
		int                      clears_0;
		int                      want;
		int                      n;
		base_w   = word_q.size();
		base_c   = code_q.size();
		clears_0 = clears;
		want     = 0;
		for (int i = 0; i < row.len; i++) begin
			w = word_at(row, i / 4);
			if (row.index == loader_pkg::idx_bios || row.index == loader_pkg::idx_cheat)
				rom.push_back(w[8 * (i % 4) +: 8]);   // Little endian file words
			else
				rom.push_back(cart_byte(row, i));
		end

		@(posedge clk_sys);
		dl_index  <= row.index;
		dl_active <= 1'b1;
		for (int i = 0; i < row.len; i += 2)
			write_half(loader_pkg::byte_addr_t'(i), {rom[i + 1], rom[i]});
		@(posedge clk_sys);
		dl_wr     <= 1'b0;
		dl_active <= 1'b0;

		n = 0;
		if (row.index == loader_pkg::idx_bios) begin
			want = base_w + row.len / 4;
			while (word_q.size() < want && n < 40) begin
				@(negedge clk_sys);
				n++;
			end
			if (word_q.size() < want) begin
				timeouts++;
				$display("%s: BIOS words still missing 40 cycles after the download", row.name);
			end
			for (int k = 0; k < want - base_w && base_w + k < word_q.size(); k++)
				check_bios(row.name, word_at(row, k), loader_pkg::bios_addr_t'(k),
					word_q[base_w + k], waddr_q[base_w + k]);
		end else if (row.index == loader_pkg::idx_cheat) begin
			want = base_c + row.len / 16;
			while (code_q.size() < want && n < 40) begin
				@(negedge clk_sys);
				n++;
			end
			if (code_q.size() < want) begin
				timeouts++;
				$display("%s: cheat codes still missing 40 cycles after the download", row.name);
			end
			for (int j = 0; j < want - base_c && base_c + j < code_q.size(); j++) begin
				code = {word_at(row, 4 * j), word_at(row, 4 * j + 1),  // Flags, address
					word_at(row, 4 * j + 2), word_at(row, 4 * j + 3)};   // Compare, replace
				check_code(row.name, j, code, code_q[base_c + j]);
			end
			check_bit(row.name, "single cheat_clear", 1'b1, clears == clears_0 + 1);
			check_bit(row.name, "clear before codes", 1'b1, codes_at_clear == base_c);
		end else begin
			while (!profile_valid && n < 20) begin
				@(negedge clk_sys);
				n++;
			end
			if (!profile_valid) begin
				timeouts++;
				$display("%s: profile_valid did not rise within 20 cycles of the end", row.name);
			end else
				check_profile(row.name, {row.flash, row.sram, row.remap}, row.max_pak);
		end

		repeat (4) @(posedge clk_sys);          // Idle gap that also catches late extras
		if (row.index == loader_pkg::idx_bios)
			check_bit(row.name, "BIOS word count", 1'b1, word_q.size() == want);
		else if (row.index == loader_pkg::idx_cheat)
			check_bit(row.name, "cheat code count", 1'b1, code_q.size() == want);
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		void'($urandom(32'he613_2343));
		reset     <= 1'b1;
		dl_active <= 1'b0;
		dl_index  <= '0;
		dl_addr   <= '0;
		dl_data   <= '0;
		dl_wr     <= 1'b0;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (2) @(posedge clk_sys);
		for (int r = 0; r < n_rows; r++)
			run_row(stream_table[r]);
		$display("Summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: gba_loader.f
+incdir+bench
source/loader_pkg.sv
source/download_decoder.sv
source/flash_tag_scanner.sv
source/title_quirk_matcher.sv
source/cart_profile.sv
source/halfword_packer.sv
source/gba_loader.sv
bench/gba_loader_tb.sv

// File: Makefile
SOURCES := $(wildcard source/*.sv bench/*.sv bench/*.svh)

obj_dir/Vgba_loader_tb: gba_loader.f $(SOURCES)
	verilator --binary --assert --timescale 1ns/100ps --top-module gba_loader_tb -f gba_loader.f

.PHONY: run clean

run: obj_dir/Vgba_loader_tb
	@out="$$(./obj_dir/Vgba_loader_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
